// File: Makefile
VERILATOR  ?= verilator
TOP        := ooo_core_tb
FILELIST   := ooo_core.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/alu_unit.sv
// single-cycle alu with a completion holding register
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
  input  wire logic                clock,
  input  wire logic                reset,
  input  wire logic                issue,
  input  wire core_pkg::alu_func_t func,
  input  wire core_pkg::data_t     op_a,
  input  wire core_pkg::data_t     op_b,
  input  wire core_pkg::reg_idx_t  dest,
  input  wire logic                grant,
  output logic                     req,
  output core_pkg::reg_idx_t       req_dest,
  output core_pkg::data_t          req_data,
  output logic                     free
);
  import core_pkg::*;

  data_t result;
  logic  held;

  always_comb begin
    case (func)
      ALU_ADD: result = op_a + op_b;
      ALU_SUB: result = op_a - op_b;
      ALU_AND: result = op_a & op_b;
      default: result = op_a ^ op_b;
    endcase
  end

  // issue may land on the same edge as a grant
  always_ff @(posedge clock) begin
    if (reset) begin
      held <= 1'b0;
    end else if (issue) begin
      held <= 1'b1;
    end else if (grant) begin
      held <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      req_dest <= dest;
      req_data <= result;
    end
  end

  assign req  = held;
  assign free = ~held | grant;

endmodule

`default_nettype wire

// File: design/complete_select.sv
// completion select: fixed priority grant, write-back port, registered result bus
`timescale 1ns/1ps
`default_nettype none

module complete_select (
  input  wire logic               clock,
  input  wire logic               reset,
  // alu offer
  input  wire logic               alu_req,
  input  wire core_pkg::reg_idx_t alu_dest,
  input  wire core_pkg::data_t    alu_data,
  output logic                    alu_grant,
  // multiplier offer
  input  wire logic               mult_req,
  input  wire core_pkg::reg_idx_t mult_dest,
  input  wire core_pkg::data_t    mult_data,
  output logic                    mult_grant,
  // write-back to register state
  output logic                    wr_en,
  output core_pkg::reg_idx_t      wr_idx,
  output core_pkg::data_t         wr_data,
  // cdb, one cycle behind write-back
  output logic                    cdb_valid,
  output core_pkg::reg_idx_t      cdb_tag,
  output core_pkg::data_t         cdb_data
);

  // multiplier first, it has waited longer
  assign mult_grant = mult_req;
  assign alu_grant  = alu_req & ~mult_req;

  // one result per cycle
  assign wr_en   = alu_req | mult_req;
  assign wr_idx  = mult_req ? mult_dest : alu_dest;
  assign wr_data = mult_req ? mult_data : alu_data;

  //////////////////////////////
  // broadcast register
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= wr_en;
    end
  end

  // tag and data only matter while valid
  always_ff @(posedge clock) begin
    if (wr_en) begin
      cdb_tag  <= wr_idx;
      cdb_data <= wr_data;
    end
  end

endmodule

`default_nettype wire

// File: design/core_pkg.sv
// core package: data and index types, opcodes, alu functions, instruction formats
`default_nettype none

package core_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////
  localparam int DATA_W    = 32;
  localparam int NUM_REGS  = 8;
  localparam int REG_IDX_W = $clog2(NUM_REGS);

  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  //////////////////////////////
  // encodings
  //////////////////////////////
  // top nibble of the word, codes 6 to f are illegal
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_XOR  = 4'h3,
    OP_ADDI = 4'h4,
    OP_MUL  = 4'h5
  } opcode_t;

  // set by decode, consumed by the alu
  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_XOR
  } alu_func_t;

  //////////////////////////////
  // instruction word
  //////////////////////////////
  // register form
  typedef struct packed {
    opcode_t     opcode;  // 31:28
    reg_idx_t    dest;    // 27:25
    reg_idx_t    src_a;   // 24:22
    reg_idx_t    src_b;   // 21:19
    logic [18:0] unused;
  } r_format_t;

  // immediate form, opcode/dest/src_a shared with register form
  typedef struct packed {
    opcode_t            opcode;
    reg_idx_t           dest;
    reg_idx_t           src_a;
    logic [5:0]         unused;  // 21:16
    logic signed [15:0] imm;
  } i_format_t;

  typedef union packed {
    r_format_t r;
    i_format_t i;
  } inst_word_t;

endpackage

`default_nettype wire

// File: design/inst_decode.sv
// instruction decode: field split, hazard check, ready and issue strobes, operand b mux
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
  input  wire logic                 in_valid,
  input  wire core_pkg::inst_word_t in_inst,
  output logic                      in_ready,
  // register file side
  output core_pkg::reg_idx_t        src_a_idx,
  output core_pkg::reg_idx_t        src_b_idx,
  input  wire logic                 busy_a,
  input  wire logic                 busy_b,
  input  wire logic                 busy_dest,
  input  wire core_pkg::data_t      rd_b,
  // unit occupancy
  input  wire logic                 alu_free,
  input  wire logic                 mult_free,
  // issue side
  output logic                      alu_issue,
  output logic                      mult_issue,
  output logic                      set_busy,
  output core_pkg::reg_idx_t        issue_dest,
  output core_pkg::alu_func_t       alu_func,
  output core_pkg::data_t           op_b,
  output logic                      illegal_seen
);
  import core_pkg::*;

  opcode_t opcode;
  logic    legal;
  logic    is_mul;
  logic    use_imm;
  data_t   imm_value;
  logic    hazard;
  logic    take;

  // opcode, dest and src_a sit at the same bits in both forms
  assign opcode     = in_inst.r.opcode;
  assign issue_dest = in_inst.r.dest;
  assign src_a_idx  = in_inst.r.src_a;
  // only meaningful for register form
  assign src_b_idx  = in_inst.r.src_b;

  always_comb begin
    legal    = 1'b1;
    is_mul   = 1'b0;
    use_imm  = 1'b0;
    alu_func = ALU_ADD;
    case (opcode)
      OP_ADD:  alu_func = ALU_ADD;
      OP_SUB:  alu_func = ALU_SUB;
      OP_AND:  alu_func = ALU_AND;
      OP_XOR:  alu_func = ALU_XOR;
      // addi reuses the alu adder
      OP_ADDI: use_imm  = 1'b1;
      OP_MUL:  is_mul   = 1'b1;
      default: legal    = 1'b0;
    endcase
  end

  // immediate form read, sign-extended to a full word
  assign imm_value = {{(DATA_W-16){in_inst.i.imm[15]}}, in_inst.i.imm};
  assign op_b      = use_imm ? imm_value : rd_b;

  // raw/waw via busy bits, structural via unit holding registers
  // src_b is don't-care bits for immediate form
  assign hazard = busy_a | (busy_b & ~use_imm) | busy_dest |
                  (is_mul ? ~mult_free : ~alu_free);

  // illegal opcodes never stall
  assign in_ready = ~legal | ~hazard;
  assign take     = in_valid & in_ready;

  // one strobe per transfer
  assign alu_issue    = take & legal & ~is_mul;
  assign mult_issue   = take & legal & is_mul;
  assign set_busy     = alu_issue | mult_issue;
  assign illegal_seen = take & ~legal;

endmodule

`default_nettype wire

// File: design/mult_unit.sv
// iterative shift-add multiplier, fixed latency, with a completion holding register
`timescale 1ns/1ps
`default_nettype none

module mult_unit #(
  parameter int MULT_CYCLES = 4
) (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire logic               issue,
  input  wire core_pkg::data_t    op_a,
  input  wire core_pkg::data_t    op_b,
  input  wire core_pkg::reg_idx_t dest,
  input  wire logic               grant,
  output logic                    req,
  output core_pkg::reg_idx_t      req_dest,
  output core_pkg::data_t         req_data,
  output logic                    free
);
  import core_pkg::*;

  // multiplier bits consumed per step, MULT_CYCLES steps cover the word
  localparam int STEP  = (DATA_W + MULT_CYCLES - 1) / MULT_CYCLES;
  localparam int CNT_W = $clog2(MULT_CYCLES);

  logic             busy;
  logic [CNT_W-1:0] count;
  data_t            acc;
  data_t            mcand;
  data_t            mplier;
  data_t            step_acc;
  data_t            step_mcand;
  data_t            step_mplier;
  data_t            partial;
  logic             stepping;

  // first step runs straight from the operands on the issue edge
  always_comb begin
    step_acc    = issue ? '0   : acc;
    step_mcand  = issue ? op_a : mcand;
    step_mplier = issue ? op_b : mplier;
    partial     = step_mcand * data_t'(step_mplier[STEP-1:0]);
  end

  assign stepping = issue | (busy & (count != '0));

  //////////////////////////////
  // control
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (issue) begin
      busy  <= 1'b1;
      count <= CNT_W'(MULT_CYCLES - 1);
    end else if (grant) begin
      busy  <= 1'b0;
    end else if (stepping) begin
      count <= count - 1'b1;
    end
  end

  //////////////////////////////
  // datapath
  //////////////////////////////
  // low word only, upper product bits dropped
  always_ff @(posedge clock) begin
    if (stepping) begin
      acc    <= step_acc + partial;
      mcand  <= step_mcand << STEP;
      mplier <= step_mplier >> STEP;
    end
    if (issue) begin
      req_dest <= dest;
    end
  end

  // result sits in acc once the count runs out
  assign req      = busy & (count == '0);
  assign req_data = acc;
  assign free     = ~busy | grant;

endmodule

`default_nettype wire

// File: design/ooo_core.sv
// core top level: decode, register state, alu, multiplier, completion select
`timescale 1ns/1ps
`default_nettype none

module ooo_core #(
  parameter int MULT_CYCLES = 4
) (
  input  wire logic                 clock,
  input  wire logic                 reset,
  // instruction input, valid/ready
  input  wire logic                 in_valid,
  output logic                      in_ready,
  input  wire core_pkg::inst_word_t in_inst,
  // result bus
  output logic                      cdb_valid,
  output core_pkg::reg_idx_t        cdb_tag,
  output core_pkg::data_t           cdb_data,
  output logic                      illegal
);
  import core_pkg::*;

  // decode to register state
  reg_idx_t  src_a_idx;
  reg_idx_t  src_b_idx;
  reg_idx_t  issue_dest;
  logic      busy_a;
  logic      busy_b;
  logic      busy_dest;
  logic      set_busy;
  logic      illegal_seen;
  data_t     rd_a;
  data_t     rd_b;
  // issue to units
  logic      alu_issue;
  logic      mult_issue;
  alu_func_t alu_func;
  data_t     op_b;
  logic      alu_free;
  logic      mult_free;
  // units to completion
  logic      alu_req;
  logic      alu_grant;
  reg_idx_t  alu_dest;
  data_t     alu_data;
  logic      mult_req;
  logic      mult_grant;
  reg_idx_t  mult_dest;
  data_t     mult_data;
  // write-back
  logic      wr_en;
  reg_idx_t  wr_idx;
  data_t     wr_data;

  inst_decode i_decode (
    .in_valid(in_valid), .in_inst(in_inst), .in_ready(in_ready),
    .src_a_idx(src_a_idx), .src_b_idx(src_b_idx),
    .busy_a(busy_a), .busy_b(busy_b), .busy_dest(busy_dest), .rd_b(rd_b),
    .alu_free(alu_free), .mult_free(mult_free),
    .alu_issue(alu_issue), .mult_issue(mult_issue), .set_busy(set_busy),
    .issue_dest(issue_dest), .alu_func(alu_func), .op_b(op_b),
    .illegal_seen(illegal_seen)
  );

  reg_state i_regs (
    .clock(clock), .reset(reset),
    .src_a_idx(src_a_idx), .src_b_idx(src_b_idx), .dest_idx(issue_dest),
    .rd_a(rd_a), .rd_b(rd_b),
    .busy_a(busy_a), .busy_b(busy_b), .busy_dest(busy_dest),
    .set_busy(set_busy), .set_idx(issue_dest),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
    .illegal_seen(illegal_seen), .illegal(illegal)
  );

  alu_unit i_alu (
    .clock(clock), .reset(reset),
    .issue(alu_issue), .func(alu_func), .op_a(rd_a), .op_b(op_b), .dest(issue_dest),
    .grant(alu_grant), .req(alu_req), .req_dest(alu_dest), .req_data(alu_data),
    .free(alu_free)
  );

  // register form only, so op_b is the rd_b read
  mult_unit #(
    .MULT_CYCLES(MULT_CYCLES)
  ) i_mult (
    .clock(clock), .reset(reset),
    .issue(mult_issue), .op_a(rd_a), .op_b(op_b), .dest(issue_dest),
    .grant(mult_grant), .req(mult_req), .req_dest(mult_dest), .req_data(mult_data),
    .free(mult_free)
  );

  complete_select i_select (
    .clock(clock), .reset(reset),
    .alu_req(alu_req), .alu_dest(alu_dest), .alu_data(alu_data), .alu_grant(alu_grant),
    .mult_req(mult_req), .mult_dest(mult_dest), .mult_data(mult_data),
    .mult_grant(mult_grant),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
  );

endmodule

`default_nettype wire

// File: design/reg_state.sv
// register state: register file, per-register busy bits, sticky illegal flag
`timescale 1ns/1ps
`default_nettype none

module reg_state (
  input  wire logic               clock,
  input  wire logic               reset,
  // combinational read side
  input  wire core_pkg::reg_idx_t src_a_idx,
  input  wire core_pkg::reg_idx_t src_b_idx,
  input  wire core_pkg::reg_idx_t dest_idx,
  output core_pkg::data_t         rd_a,
  output core_pkg::data_t         rd_b,
  output logic                    busy_a,
  output logic                    busy_b,
  output logic                    busy_dest,
  // issue marks the destination busy
  input  wire logic               set_busy,
  input  wire core_pkg::reg_idx_t set_idx,
  // write-back from completion
  input  wire logic               wr_en,
  input  wire core_pkg::reg_idx_t wr_idx,
  input  wire core_pkg::data_t    wr_data,
  input  wire logic               illegal_seen,
  output logic                    illegal
);
  import core_pkg::*;

  data_t               regs [NUM_REGS];
  logic [NUM_REGS-1:0] busy;

  // no bypass, dependent reads see the value the cycle after write-back
  assign rd_a      = regs[src_a_idx];
  assign rd_b      = regs[src_b_idx];
  assign busy_a    = busy[src_a_idx];
  assign busy_b    = busy[src_b_idx];
  assign busy_dest = busy[dest_idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // clear first, then set, so a set on the same index wins
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (wr_en) begin
        busy[wr_idx] <= 1'b0;
      end
      if (set_busy) begin
        busy[set_idx] <= 1'b1;
      end
    end
  end

  // stays high until reset
  always_ff @(posedge clock) begin
    if (reset) begin
      illegal <= 1'b0;
    end else if (illegal_seen) begin
      illegal <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: ooo_core.f
+incdir+test
design/core_pkg.sv
design/inst_decode.sv
design/reg_state.sv
design/alu_unit.sv
design/mult_unit.sv
design/complete_select.sv
design/ooo_core.sv
test/ooo_core_tb.sv

// File: test/ooo_core_cases.svh
// stimulus table with the case count and the instruction rows
`ifndef OOO_CORE_CASES_SVH
`define OOO_CORE_CASES_SVH

// each row holds opcode, dest, src_a, src_b, imm, imm mode and overtake
// imm mode 0 fixed, 1 random positive, 2 random negative
// overtake set means this row must broadcast before the row above it
localparam int NUM_CASES = 22;

localparam logic [31:0] CASES [NUM_CASES] = '{
  // seed registers through addi with both signs
  {OP_ADDI, 3'd1, 3'd0, 3'd0, 16'h0000, 2'd1, 1'b0},
  {OP_ADDI, 3'd2, 3'd0, 3'd0, 16'h0000, 2'd2, 1'b0},
  {OP_ADDI, 3'd3, 3'd1, 3'd0, 16'hfff0, 2'd0, 1'b0},
  // plain alu ops on the seeded values
  {OP_ADD,  3'd4, 3'd1, 3'd2, 16'h0000, 2'd0, 1'b0},
  {OP_SUB,  3'd5, 3'd1, 3'd2, 16'h0000, 2'd0, 1'b0},
  {OP_AND,  3'd6, 3'd1, 3'd2, 16'h0000, 2'd0, 1'b0},
  {OP_XOR,  3'd7, 3'd1, 3'd2, 16'h0000, 2'd0, 1'b0},
  // reads and rewrites its own source
  {OP_ADDI, 3'd1, 3'd1, 3'd0, 16'h0000, 2'd1, 1'b0},
  // mul chain with raw and waw on r4
  {OP_MUL,  3'd3, 3'd1, 3'd2, 16'h0000, 2'd0, 1'b0},
  {OP_MUL,  3'd4, 3'd3, 3'd1, 16'h0000, 2'd0, 1'b0},
  {OP_ADD,  3'd4, 3'd4, 3'd3, 16'h0000, 2'd0, 1'b0},
  {OP_MUL,  3'd5, 3'd4, 3'd4, 16'h0000, 2'd0, 1'b0},
  // waw alone on r5, sources are free so only the busy dest holds it back
  {OP_SUB,  3'd5, 3'd1, 3'd2, 16'h0000, 2'd0, 1'b0},
  // independent addi right behind a mul finishes first
  {OP_MUL,  3'd6, 3'd2, 3'd3, 16'h0000, 2'd0, 1'b0},
  {OP_ADDI, 3'd7, 3'd1, 3'd0, 16'h0005, 2'd0, 1'b1},
  {OP_XOR,  3'd0, 3'd2, 3'd3, 16'h0000, 2'd0, 1'b0},
  // illegal codes and then work continues
  {4'ha,    3'd5, 3'd1, 3'd2, 16'h0000, 2'd0, 1'b0},
  {OP_ADD,  3'd0, 3'd6, 3'd7, 16'h0000, 2'd0, 1'b0},
  {4'hf,    3'd3, 3'd0, 3'd0, 16'h0000, 2'd0, 1'b0},
  {OP_MUL,  3'd2, 3'd0, 3'd5, 16'h0000, 2'd0, 1'b0},
  {OP_ADDI, 3'd6, 3'd2, 3'd0, 16'h0000, 2'd2, 1'b0},
  {OP_AND,  3'd1, 3'd6, 3'd4, 16'h0000, 2'd0, 1'b0}
};

`endif

// File: test/ooo_core_tb.sv
// testbench for the core: clock, reset, table driver, reference model, monitor, watchdog
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;
  import core_pkg::*;

  localparam int MULT_CYCLES = 4;
  localparam int CLOCK_NS    = 10;
  // budget per table row
  localparam int CASE_CYCLES = 40;

  `include "ooo_core_cases.svh"

  logic       clock;
  logic       reset;
  logic       in_valid;
  logic       in_ready;
  inst_word_t in_inst;
  logic       cdb_valid;
  reg_idx_t   cdb_tag;
  data_t      cdb_data;
  logic       illegal;

  // reference state in program order
  data_t model_regs [NUM_REGS];
  logic  model_illegal;
  // expected results per destination, oldest first
  data_t exp_q  [NUM_REGS][$];
  int    case_q [NUM_REGS][$];
  time   done_time [NUM_CASES];
  int    outstanding;
  int    checks;
  int    errors;

  ooo_core #(
    .MULT_CYCLES(MULT_CYCLES)
  ) i_dut (
    .clock(clock), .reset(reset),
    .in_valid(in_valid), .in_ready(in_ready), .in_inst(in_inst),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
    .illegal(illegal)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_NS / 2) clock = ~clock;
  end

  //////////////////////////////
  // compare tasks
  //////////////////////////////
  task automatic check_data(input reg_idx_t tag, input data_t actual, input data_t expected,
                            input int n);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %0t: case %0d r%0d result %h, expected %h", $time, n, tag, actual,
               expected);
    end
  endtask

  task automatic check_flag(input string what, input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  // one instruction evaluated from the opcode rules
  function automatic data_t model_result(input logic [3:0] op, input data_t a, input data_t b,
                                         input logic [15:0] imm);
    data_t imm_ext;
    imm_ext = {{16{imm[15]}}, imm};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      OP_ADDI: return a + imm_ext;
      OP_MUL:  return a * b;
      default: return '0;
    endcase
  endfunction

  //////////////////////////////
  // result bus monitor
  //////////////////////////////
  // sampled mid-cycle, away from the edge
  always @(negedge clock) begin : monitor
    int    n;
    data_t expected;
    if (!reset && cdb_valid) begin
      if (exp_q[cdb_tag].size() == 0) begin
        errors++;
        $display("result broadcast on r%0d at %0t with no instruction outstanding", cdb_tag,
                 $time);
      end else begin
        n           = case_q[cdb_tag].pop_front();
        expected    = exp_q[cdb_tag].pop_front();
        done_time[n] = $time;
        outstanding--;
        check_data(cdb_tag, cdb_data, expected, n);
      end
    end
  end

  //////////////////////////////
  // driver
  //////////////////////////////
  initial begin : driver
    logic [31:0] row;
    logic [31:0] word;
    logic [3:0]  op;
    reg_idx_t    dest;
    reg_idx_t    src_a;
    reg_idx_t    src_b;
    logic [15:0] imm;
    logic [1:0]  mode;
    data_t       expected;
    logic        accepted;
    void'($urandom(32'h8f21));
    reset         = 1'b1;
    in_valid      = 1'b0;
    in_inst       = '0;
    model_illegal = 1'b0;
    outstanding   = 0;
    checks        = 0;
    errors        = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < NUM_CASES; i++) begin
      done_time[i] = 0;
    end
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    check_flag("in_ready after reset", in_ready, 1'b1);
    check_flag("cdb_valid after reset", cdb_valid, 1'b0);
    check_flag("illegal after reset", illegal, 1'b0);

    for (int n = 0; n < NUM_CASES; n++) begin
      row   = CASES[n];
      op    = row[31:28];
      dest  = row[27:25];
      src_a = row[24:22];
      src_b = row[21:19];
      imm   = row[18:3];
      mode  = row[2:1];
      if (mode == 2'd1) begin
        imm = {1'b0, 15'($urandom)};
      end else if (mode == 2'd2) begin
        imm = {1'b1, 15'($urandom)};
      end
      // immediate form carries imm in the low half
      if (op == OP_ADDI) begin
        word = {op, dest, src_a, 6'b0, imm};
      end else begin
        word = {op, dest, src_a, src_b, 19'b0};
      end
      if (op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_MUL}) begin
        expected         = model_result(op, model_regs[src_a], model_regs[src_b], imm);
        model_regs[dest] = expected;
        exp_q[dest].push_back(expected);
        case_q[dest].push_back(n);
        outstanding++;
      end else begin
        model_illegal = 1'b1;
      end
      in_inst  = word;
      in_valid = 1'b1;
      // hold until ready is seen ahead of an edge
      do begin
        @(negedge clock);
        accepted = in_ready;
        @(posedge clock);
        #1;
      end while (!accepted);
      in_valid = 1'b0;
      check_flag("illegal", illegal, model_illegal);
    end

    // drain, then a few idle cycles for stray broadcasts
    while (outstanding > 0) begin
      @(posedge clock);
    end
    repeat (4) @(posedge clock);

    for (int n = 1; n < NUM_CASES; n++) begin
      if (CASES[n][0]) begin
        checks++;
        if (done_time[n] == 0 || done_time[n] >= done_time[n-1]) begin
          errors++;
          $display("case %0d did not complete ahead of case %0d", n, n - 1);
        end
      end
    end
    check_flag("in_ready when idle", in_ready, 1'b1);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // whole table plus reset and drain margin
  initial begin : watchdog
    #(CLOCK_NS * (NUM_CASES * CASE_CYCLES + 20));
    $display("timeout, the core stopped accepting or completing instructions");
    $display("checks %0d, errors %0d", checks, errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire
